// ==== rtl/host_rd_pkg.sv ====
// Sizes assume 64-bit lines, a 4 KB page, power-of-two buffer depths and tags equal to ROB slots
`default_nettype none

package host_rd_pkg;

    // ====================================================================
    // Line and address geometry
    // ====================================================================

    // One cache line beat on the AFU and completion data paths
    localparam int DATA_WIDTH = 64;
    localparam int LINE_BYTES = 8;
    localparam int ADDR_WIDTH = 32;

    // Length fields carry lines minus one, so a burst is at most 16 lines
    localparam int LEN_WIDTH = 4;
    localparam int ID_WIDTH = 4;

    // A line count needs one bit more than a length field
    localparam int CHUNK_WIDTH = LEN_WIDTH + 1;

    // Byte offset bits inside a line
    localparam int LINE_OFS_BITS = $clog2(LINE_BYTES);

    // A TLP may not cross a 4 KB page, which is this many lines
    localparam int PAGE_LINES = 512;
    localparam int PAGE_BITS = $clog2(PAGE_LINES);
    localparam int MAX_PAYLOAD_LINES = 4;

    // ====================================================================
    // Reorder buffer and credits
    // ====================================================================

    // The slot index doubles as the TLP tag
    localparam int ROB_SLOTS = 16;
    localparam int SLOT_WIDTH = 4;

    // Burst buffer depth equals the AFU's initial request credit
    localparam int AR_BUF_DEPTH = 2;
    localparam int AR_PTR_WIDTH = $clog2(AR_BUF_DEPTH);

    localparam int TLP_CREDITS_INIT = 2;
    localparam int TLP_CRD_WIDTH = $clog2(TLP_CREDITS_INIT + 1);
    localparam int R_CREDITS_INIT = 4;
    localparam int R_CRD_WIDTH = $clog2(R_CREDITS_INIT + 1);

endpackage

`default_nettype wire

// ==== rtl/host_rd_burst_splitter.sv ====
// Issues one TLP per cycle at most and expects line-aligned addresses and honest AFU credit use
`timescale 1ns/1ns
`default_nettype none

module host_rd_burst_splitter
(
    input  logic                                       afu_clk,
    input  logic                                       arst_n,

    // AFU burst requests, one per credit
    input  logic                                       ar_valid,
    input  logic [host_rd_pkg::ADDR_WIDTH-1:0]         ar_addr,
    input  logic [host_rd_pkg::LEN_WIDTH-1:0]          ar_len,
    input  logic [host_rd_pkg::ID_WIDTH-1:0]           ar_id,
    output logic                                       ar_credit,

    // Read TLPs toward the host
    output logic                                       tlp_req_valid,
    output logic [host_rd_pkg::ADDR_WIDTH-1:0]         tlp_req_addr,
    output logic [host_rd_pkg::LEN_WIDTH-1:0]          tlp_req_len,
    output logic [host_rd_pkg::SLOT_WIDTH-1:0]         tlp_req_tag,
    input  logic                                       tlp_credit,

    // Slot allocation in the ROB
    output logic                                       alloc_valid,
    output logic [host_rd_pkg::CHUNK_WIDTH-1:0]        alloc_lines,
    output logic [host_rd_pkg::ID_WIDTH-1:0]           alloc_id,
    output logic                                       alloc_last,
    input  logic [host_rd_pkg::SLOT_WIDTH-1:0]         alloc_tag,
    input  logic [host_rd_pkg::SLOT_WIDTH:0]           free_slots
);

    // Burst buffer storage, indexed by the read and write pointers
    logic [host_rd_pkg::ADDR_WIDTH-1:0]   buf_addr [host_rd_pkg::AR_BUF_DEPTH];
    logic [host_rd_pkg::LEN_WIDTH-1:0]    buf_len [host_rd_pkg::AR_BUF_DEPTH];
    logic [host_rd_pkg::ID_WIDTH-1:0]     buf_id [host_rd_pkg::AR_BUF_DEPTH];
    logic [host_rd_pkg::AR_PTR_WIDTH-1:0] wr_ptr;
    logic [host_rd_pkg::AR_PTR_WIDTH-1:0] rd_ptr;
    logic [host_rd_pkg::AR_PTR_WIDTH:0]   buf_count;

    // State of the burst at the buffer head while it is being cut up
    logic                                 active;
    logic [host_rd_pkg::ADDR_WIDTH-1:0]   cur_addr;
    logic [host_rd_pkg::CHUNK_WIDTH-1:0]  remaining;
    logic [host_rd_pkg::TLP_CRD_WIDTH-1:0] tlp_credits;

    logic [host_rd_pkg::PAGE_BITS:0]      page_left;
    logic [host_rd_pkg::PAGE_BITS:0]      chunk_wide;
    logic [host_rd_pkg::CHUNK_WIDTH-1:0]  chunk;
    logic                                 last_chunk;
    logic                                 issue;
    logic                                 burst_done;
    logic                                 load;

    // ====================================================================
    // Chunk sizing
    // ====================================================================

    // Chunk is the least of the remaining lines, the payload limit and the page room
    always_comb
    begin
        page_left = (host_rd_pkg::PAGE_BITS + 1)'(host_rd_pkg::PAGE_LINES)
                    - {1'b0, cur_addr[host_rd_pkg::LINE_OFS_BITS +: host_rd_pkg::PAGE_BITS]};
        chunk_wide = (host_rd_pkg::PAGE_BITS + 1)'(host_rd_pkg::MAX_PAYLOAD_LINES);
        if ((host_rd_pkg::PAGE_BITS + 1)'(remaining) < chunk_wide)
        begin
            chunk_wide = (host_rd_pkg::PAGE_BITS + 1)'(remaining);
        end
        if (page_left < chunk_wide)
        begin
            chunk_wide = page_left;
        end
        chunk = chunk_wide[host_rd_pkg::CHUNK_WIDTH-1:0];
    end

    assign last_chunk = (chunk == remaining);

    // A TLP goes out only with a credit in hand and room reserved for every line
    assign issue = active && (tlp_credits != '0) && (free_slots >= chunk);
    assign burst_done = issue && last_chunk;
    assign load = !active && (buf_count != '0);

    // The tag is the ROB tail, which advances in the same cycle
    assign tlp_req_valid = issue;
    assign tlp_req_addr = cur_addr;
    assign tlp_req_len = host_rd_pkg::LEN_WIDTH'(chunk - 1'b1);
    assign tlp_req_tag = alloc_tag;

    assign alloc_valid = issue;
    assign alloc_lines = chunk;
    assign alloc_id = buf_id[rd_ptr];
    assign alloc_last = last_chunk;

    // ====================================================================
    // Control state
    // ====================================================================

    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            buf_count <= '0;
            active <= 1'b0;
            remaining <= '0;
            ar_credit <= 1'b0;
            tlp_credits <= host_rd_pkg::TLP_CRD_WIDTH'(host_rd_pkg::TLP_CREDITS_INIT);
        end
        else
        begin
            if (ar_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            buf_count <= buf_count + (host_rd_pkg::AR_PTR_WIDTH + 1)'(ar_valid)
                         - (host_rd_pkg::AR_PTR_WIDTH + 1)'(burst_done);

            // Length field holds lines minus one
            if (load)
            begin
                active <= 1'b1;
                remaining <= {1'b0, buf_len[rd_ptr]} + 1'b1;
            end
            else if (issue)
            begin
                remaining <= remaining - chunk;
            end

            // The buffer entry is freed and its credit returned once the last chunk is out
            if (burst_done)
            begin
                active <= 1'b0;
                rd_ptr <= rd_ptr + 1'b1;
            end
            ar_credit <= burst_done;

            tlp_credits <= tlp_credits - host_rd_pkg::TLP_CRD_WIDTH'(issue)
                           + host_rd_pkg::TLP_CRD_WIDTH'(tlp_credit);
        end
    end

    // Buffer contents and the running address carry no reset
    always_ff @(posedge afu_clk)
    begin
        if (ar_valid)
        begin
            buf_addr[wr_ptr] <= ar_addr;
            buf_len[wr_ptr] <= ar_len;
            buf_id[wr_ptr] <= ar_id;
        end
        if (load)
        begin
            cur_addr <= buf_addr[rd_ptr];
        end
        else if (issue)
        begin
            cur_addr <= cur_addr + (host_rd_pkg::ADDR_WIDTH'(chunk) << host_rd_pkg::LINE_OFS_BITS);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/host_rd_rob.sv ====
// Assumes each completion tag targets an allocated empty slot and allocations never exceed free space
`timescale 1ns/1ns
`default_nettype none

module host_rd_rob
(
    input  logic                                  afu_clk,
    input  logic                                  arst_n,

    // Allocation from the splitter
    input  logic                                  alloc_valid,
    input  logic [host_rd_pkg::CHUNK_WIDTH-1:0]   alloc_lines,
    input  logic [host_rd_pkg::ID_WIDTH-1:0]      alloc_id,
    input  logic                                  alloc_last,
    output logic [host_rd_pkg::SLOT_WIDTH-1:0]    alloc_tag,
    output logic [host_rd_pkg::SLOT_WIDTH:0]      free_slots,

    // Host completions, one line per cycle
    input  logic                                  cpl_valid,
    input  logic [host_rd_pkg::SLOT_WIDTH-1:0]    cpl_tag,
    input  logic [host_rd_pkg::DATA_WIDTH-1:0]    cpl_data,

    // In-order head toward the response sender
    output logic                                  head_valid,
    output logic [host_rd_pkg::DATA_WIDTH-1:0]    head_data,
    output logic [host_rd_pkg::ID_WIDTH-1:0]      head_id,
    output logic                                  head_last,
    input  logic                                  head_pop
);

    // Slot payload
    logic [host_rd_pkg::DATA_WIDTH-1:0]  slot_data [host_rd_pkg::ROB_SLOTS];
    logic [host_rd_pkg::ID_WIDTH-1:0]    slot_id [host_rd_pkg::ROB_SLOTS];
    logic [host_rd_pkg::ROB_SLOTS-1:0]   slot_last;

    // A slot is filled from its completion until the sender pops it
    logic [host_rd_pkg::ROB_SLOTS-1:0]   slot_filled;

    logic [host_rd_pkg::SLOT_WIDTH-1:0]  head;
    logic [host_rd_pkg::SLOT_WIDTH-1:0]  tail;
    logic [host_rd_pkg::SLOT_WIDTH:0]    used;

    // Distance of each slot from the tail, and whether this allocation covers it
    logic [host_rd_pkg::SLOT_WIDTH-1:0]  alloc_ofs [host_rd_pkg::ROB_SLOTS];
    logic [host_rd_pkg::ROB_SLOTS-1:0]   alloc_hit;

    // ====================================================================
    // Allocation window
    // ====================================================================

    // Offsets wrap modulo the slot count like the tags do
    always_comb
    begin
        for (int i = 0; i < host_rd_pkg::ROB_SLOTS; i++)
        begin
            alloc_ofs[i] = host_rd_pkg::SLOT_WIDTH'(i) - tail;
            alloc_hit[i] = alloc_valid && ({1'b0, alloc_ofs[i]} < alloc_lines);
        end
    end

    assign alloc_tag = tail;
    assign free_slots = (host_rd_pkg::SLOT_WIDTH + 1)'(host_rd_pkg::ROB_SLOTS) - used;

    // The head is ready as soon as its own line has landed
    assign head_valid = slot_filled[head];
    assign head_data = slot_data[head];
    assign head_id = slot_id[head];
    assign head_last = slot_last[head];

    // ====================================================================
    // Pointers and fill state
    // ====================================================================

    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            head <= '0;
            tail <= '0;
            used <= '0;
            slot_filled <= '0;
        end
        else
        begin
            if (alloc_valid)
            begin
                tail <= tail + alloc_lines[host_rd_pkg::SLOT_WIDTH-1:0];
            end
            used <= used + (alloc_valid ? alloc_lines : '0)
                    - (host_rd_pkg::SLOT_WIDTH + 1)'(head_pop);

            // A completion never lands on the slot being popped, so order is free
            if (cpl_valid)
            begin
                slot_filled[cpl_tag] <= 1'b1;
            end
            if (head_pop)
            begin
                slot_filled[head] <= 1'b0;
                head <= head + 1'b1;
            end
        end
    end

    // Payload is rewritten on every allocation and completion
    always_ff @(posedge afu_clk)
    begin
        if (cpl_valid)
        begin
            slot_data[cpl_tag] <= cpl_data;
        end
        for (int i = 0; i < host_rd_pkg::ROB_SLOTS; i++)
        begin
            if (alloc_hit[i])
            begin
                slot_id[i] <= alloc_id;
                // Only the final line of the final chunk closes the burst
                slot_last[i] <= alloc_last && ({1'b0, alloc_ofs[i]} == alloc_lines - 1'b1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/host_rd_rsp_sender.sv ====
// Expects the AFU to return no more r_credit pulses than responses it has received
`timescale 1ns/1ns
`default_nettype none

module host_rd_rsp_sender
(
    input  logic                                  afu_clk,
    input  logic                                  arst_n,

    // Head of the reorder buffer
    input  logic                                  head_valid,
    input  logic [host_rd_pkg::DATA_WIDTH-1:0]    head_data,
    input  logic [host_rd_pkg::ID_WIDTH-1:0]      head_id,
    input  logic                                  head_last,
    output logic                                  head_pop,

    // Response channel to the AFU
    output logic                                  r_valid,
    output logic [host_rd_pkg::DATA_WIDTH-1:0]    r_data,
    output logic [host_rd_pkg::ID_WIDTH-1:0]      r_id,
    output logic                                  r_last,
    input  logic                                  r_credit
);

    // Responses the AFU can still accept
    logic [host_rd_pkg::R_CRD_WIDTH-1:0] r_credits;

    // ====================================================================
    // Pop decision
    // ====================================================================

    // A line leaves the ROB only when the AFU has room for it
    assign head_pop = head_valid && (r_credits != '0);

    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            r_valid <= 1'b0;
            r_credits <= host_rd_pkg::R_CRD_WIDTH'(host_rd_pkg::R_CREDITS_INIT);
        end
        else
        begin
            r_valid <= head_pop;
            // A credit returning in the pop cycle is counted at once
            r_credits <= r_credits - host_rd_pkg::R_CRD_WIDTH'(head_pop)
                         + host_rd_pkg::R_CRD_WIDTH'(r_credit);
        end
    end

    // Output register loads with the pop and is qualified by r_valid
    always_ff @(posedge afu_clk)
    begin
        if (head_pop)
        begin
            r_data <= head_data;
            r_id <= head_id;
            r_last <= head_last;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/host_rd_top.sv ====
// Single clock domain on afu_clk with credit flow control and completions that are never held off
`timescale 1ns/1ns
`default_nettype none

module host_rd_top
(
    input  logic                                  afu_clk,
    input  logic                                  arst_n,

    // AFU request channel
    input  logic                                  ar_valid,
    input  logic [host_rd_pkg::ADDR_WIDTH-1:0]    ar_addr,
    input  logic [host_rd_pkg::LEN_WIDTH-1:0]     ar_len,
    input  logic [host_rd_pkg::ID_WIDTH-1:0]      ar_id,
    output logic                                  ar_credit,

    // TLP request channel
    output logic                                  tlp_req_valid,
    output logic [host_rd_pkg::ADDR_WIDTH-1:0]    tlp_req_addr,
    output logic [host_rd_pkg::LEN_WIDTH-1:0]     tlp_req_len,
    output logic [host_rd_pkg::SLOT_WIDTH-1:0]    tlp_req_tag,
    input  logic                                  tlp_credit,

    // Completion channel
    input  logic                                  cpl_valid,
    input  logic [host_rd_pkg::SLOT_WIDTH-1:0]    cpl_tag,
    input  logic [host_rd_pkg::DATA_WIDTH-1:0]    cpl_data,

    // Response channel
    output logic                                  r_valid,
    output logic [host_rd_pkg::DATA_WIDTH-1:0]    r_data,
    output logic [host_rd_pkg::ID_WIDTH-1:0]      r_id,
    output logic                                  r_last,
    input  logic                                  r_credit
);

    // ====================================================================
    // Splitter to ROB and ROB to sender
    // ====================================================================

    logic                                 alloc_valid;
    logic [host_rd_pkg::CHUNK_WIDTH-1:0]  alloc_lines;
    logic [host_rd_pkg::ID_WIDTH-1:0]     alloc_id;
    logic                                 alloc_last;
    logic [host_rd_pkg::SLOT_WIDTH-1:0]   alloc_tag;
    logic [host_rd_pkg::SLOT_WIDTH:0]     free_slots;

    logic                                 head_valid;
    logic [host_rd_pkg::DATA_WIDTH-1:0]   head_data;
    logic [host_rd_pkg::ID_WIDTH-1:0]     head_id;
    logic                                 head_last;
    logic                                 head_pop;

    // Cuts bursts into TLPs and reserves their slots
    host_rd_burst_splitter splitter
    (
        .afu_clk, .arst_n,
        .ar_valid, .ar_addr, .ar_len, .ar_id, .ar_credit,
        .tlp_req_valid, .tlp_req_addr, .tlp_req_len, .tlp_req_tag, .tlp_credit,
        .alloc_valid, .alloc_lines, .alloc_id, .alloc_last, .alloc_tag, .free_slots
    );

    // Sorts completions back into request order
    host_rd_rob rob
    (
        .afu_clk, .arst_n,
        .alloc_valid, .alloc_lines, .alloc_id, .alloc_last, .alloc_tag, .free_slots,
        .cpl_valid, .cpl_tag, .cpl_data,
        .head_valid, .head_data, .head_id, .head_last, .head_pop
    );

    host_rd_rsp_sender sender
    (
        .afu_clk, .arst_n,
        .head_valid, .head_data, .head_id, .head_last, .head_pop,
        .r_valid, .r_data, .r_id, .r_last, .r_credit
    );

endmodule

`default_nettype wire

// ==== testbench/host_rd_checker.sv ====
// Credit count mirrors the response sender and assumes single-cycle r_credit pulses from the AFU
`timescale 1ns/1ns
`default_nettype none

module host_rd_checker
(
    input  logic                                  afu_clk,
    input  logic                                  arst_n,
    input  logic                                  tlp_req_valid,
    input  logic [host_rd_pkg::ADDR_WIDTH-1:0]    tlp_req_addr,
    input  logic [host_rd_pkg::LEN_WIDTH-1:0]     tlp_req_len,
    input  logic                                  r_valid,
    input  logic                                  r_credit,
    input  logic                                  ar_credit
);

    // Responses the AFU can still take, as seen from the ports
    int                               r_avail;

    // Line offset of the TLP start inside its page
    logic [host_rd_pkg::PAGE_BITS:0]  page_ofs;

    assign page_ofs = {1'b0, tlp_req_addr[host_rd_pkg::LINE_OFS_BITS +: host_rd_pkg::PAGE_BITS]};

    always_ff @(posedge afu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            r_avail <= host_rd_pkg::R_CREDITS_INIT;
        end
        else
        begin
            r_avail <= r_avail - int'(r_valid) + int'(r_credit);
        end
    end

    // ====================================================================
    // Protocol rules
    // ====================================================================

    // The last line of a TLP must still sit in the page of its first line
    page_safe: assert property (@(posedge afu_clk) disable iff (!arst_n)
        tlp_req_valid |-> (page_ofs + tlp_req_len + 1 <= host_rd_pkg::PAGE_LINES))
        else $error("TLP request crosses a 4 KB page");

    r_credit_held: assert property (@(posedge afu_clk) disable iff (!arst_n)
        r_valid |-> (r_avail > 0))
        else $error("Response sent while the AFU holds no free credit");

    // Nothing leaves the bridge while reset is applied
    quiet_in_reset: assert property (@(posedge afu_clk)
        !arst_n |-> (!tlp_req_valid && !r_valid && !ar_credit))
        else $error("Output active while reset is asserted");

endmodule

`default_nettype wire

// ==== testbench/host_rd_tb.sv ====
// Host model answers TLPs out of order, the AFU may hold back r_credit, and all runs on afu_clk
`timescale 1ns/1ns
`default_nettype none

module host_rd_tb;

    logic                                afu_clk = 1'b0;
    logic                                arst_n = 1'b1;
    logic                                ar_valid = 1'b0;
    logic [host_rd_pkg::ADDR_WIDTH-1:0]  ar_addr = '0;
    logic [host_rd_pkg::LEN_WIDTH-1:0]   ar_len = '0;
    logic [host_rd_pkg::ID_WIDTH-1:0]    ar_id = '0;
    logic                                tlp_credit = 1'b0;
    logic                                cpl_valid = 1'b0;
    logic [host_rd_pkg::SLOT_WIDTH-1:0]  cpl_tag = '0;
    logic [host_rd_pkg::DATA_WIDTH-1:0]  cpl_data = '0;
    logic                                r_credit = 1'b0;
    logic                                ar_credit;
    logic                                tlp_req_valid;
    logic [host_rd_pkg::ADDR_WIDTH-1:0]  tlp_req_addr;
    logic [host_rd_pkg::LEN_WIDTH-1:0]   tlp_req_len;
    logic [host_rd_pkg::SLOT_WIDTH-1:0]  tlp_req_tag;
    logic                                r_valid;
    logic [host_rd_pkg::DATA_WIDTH-1:0]  r_data;
    logic [host_rd_pkg::ID_WIDTH-1:0]    r_id;
    logic                                r_last;

    // Expected TLPs and response lines in request order
    logic [host_rd_pkg::ADDR_WIDTH-1:0]  exp_tlp_addr [$];
    logic [host_rd_pkg::LEN_WIDTH-1:0]   exp_tlp_len [$];
    logic [host_rd_pkg::SLOT_WIDTH-1:0]  exp_tlp_tag [$];
    logic [host_rd_pkg::DATA_WIDTH-1:0]  exp_r_data [$];
    logic [host_rd_pkg::ID_WIDTH-1:0]    exp_r_id [$];
    logic                                exp_r_last [$];
    int                                  next_tag = 0;

    // Host model state: lines asked for but not yet answered
    logic [host_rd_pkg::SLOT_WIDTH-1:0]  pool_tag [$];
    logic [host_rd_pkg::ADDR_WIDTH-1:0]  pool_addr [$];
    int                                  tlp_owed = 0;
    int                                  cpl_pct = 60;

    // Port event counters, updated with non-blocking writes so readers see one value per edge
    int                                  ar_returned = 0;
    int                                  ar_spent = 0;
    int                                  tlp_seen = 0;
    int                                  r_beats = 0;
    int                                  r_returned = 0;
    int                                  r_owed = 0;
    logic                                hold_credits = 1'b0;

    always #4 afu_clk = ~afu_clk;

    host_rd_top DUT
    (
        .afu_clk, .arst_n,
        .ar_valid, .ar_addr, .ar_len, .ar_id, .ar_credit,
        .tlp_req_valid, .tlp_req_addr, .tlp_req_len, .tlp_req_tag, .tlp_credit,
        .cpl_valid, .cpl_tag, .cpl_data,
        .r_valid, .r_data, .r_id, .r_last, .r_credit
    );

    bind host_rd_top host_rd_checker protocol_rules
    (
        .afu_clk(afu_clk), .arst_n(arst_n),
        .tlp_req_valid(tlp_req_valid), .tlp_req_addr(tlp_req_addr), .tlp_req_len(tlp_req_len),
        .r_valid(r_valid), .r_credit(r_credit), .ar_credit(ar_credit)
    );

    task automatic fail_with(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // ====================================================================
    // Reference model
    // ====================================================================

    // Line data is the inverted line index above the plain line index
    function automatic logic [host_rd_pkg::DATA_WIDTH-1:0] line_data(
        input logic [host_rd_pkg::ADDR_WIDTH-1:0] addr);
        logic [31:0] idx;
        idx = addr / host_rd_pkg::LINE_BYTES;
        return {~idx, idx};
    endfunction

    // Cuts a burst by the min rule and lists its TLPs and response lines
    function automatic void expect_burst(input logic [host_rd_pkg::ADDR_WIDTH-1:0] addr,
                                         input int lines,
                                         input logic [host_rd_pkg::ID_WIDTH-1:0] id);
        int rem;
        int chunk;
        int page_left;
        logic [host_rd_pkg::ADDR_WIDTH-1:0] a;
        rem = lines;
        a = addr;
        while (rem > 0)
        begin
            page_left = host_rd_pkg::PAGE_LINES
                        - int'((a / host_rd_pkg::LINE_BYTES) % host_rd_pkg::PAGE_LINES);
            chunk = (rem < host_rd_pkg::MAX_PAYLOAD_LINES) ? rem : host_rd_pkg::MAX_PAYLOAD_LINES;
            if (page_left < chunk)
            begin
                chunk = page_left;
            end
            exp_tlp_addr.push_back(a);
            exp_tlp_len.push_back(host_rd_pkg::LEN_WIDTH'(chunk - 1));
            // Slots are handed out in order, so the tag is the running line count
            exp_tlp_tag.push_back(host_rd_pkg::SLOT_WIDTH'(next_tag));
            next_tag = (next_tag + chunk) % host_rd_pkg::ROB_SLOTS;
            for (int k = 0; k < chunk; k++)
            begin
                exp_r_data.push_back(line_data(a + host_rd_pkg::ADDR_WIDTH'(k * 8)));
                exp_r_id.push_back(id);
                exp_r_last.push_back((rem == chunk) && (k == chunk - 1));
            end
            a = a + host_rd_pkg::ADDR_WIDTH'(chunk * host_rd_pkg::LINE_BYTES);
            rem = rem - chunk;
        end
    endfunction

    // ====================================================================
    // Comparing process and port counters
    // ====================================================================

    always @(posedge afu_clk)
    begin
        if (ar_credit)
        begin
            ar_returned <= ar_returned + 1;
        end
        if (r_credit)
        begin
            r_returned <= r_returned + 1;
        end
        if (tlp_req_valid)
        begin
            assert (exp_tlp_addr.size() > 0)
            else fail_with("TLP request issued with no burst left to split");
            assert (tlp_req_addr == exp_tlp_addr[0])
            else fail_with($sformatf("mismatch tlp_req_addr expected %h got %h",
                                     exp_tlp_addr[0], tlp_req_addr));
            assert (tlp_req_len == exp_tlp_len[0])
            else fail_with($sformatf("mismatch tlp_req_len expected %h got %h",
                                     exp_tlp_len[0], tlp_req_len));
            assert (tlp_req_tag == exp_tlp_tag[0])
            else fail_with($sformatf("mismatch tlp_req_tag expected %h got %h",
                                     exp_tlp_tag[0], tlp_req_tag));
            void'(exp_tlp_addr.pop_front());
            void'(exp_tlp_len.pop_front());
            void'(exp_tlp_tag.pop_front());
            tlp_seen <= tlp_seen + 1;
        end
        if (r_valid)
        begin
            assert (r_beats < r_returned + host_rd_pkg::R_CREDITS_INIT)
            else fail_with("response sent beyond the credits the AFU returned");
            assert (exp_r_data.size() > 0)
            else fail_with("response sent with no line outstanding");
            assert (r_data == exp_r_data[0])
            else fail_with($sformatf("mismatch r_data expected %h got %h", exp_r_data[0], r_data));
            assert (r_id == exp_r_id[0])
            else fail_with($sformatf("mismatch r_id expected %h got %h", exp_r_id[0], r_id));
            assert (r_last == exp_r_last[0])
            else fail_with($sformatf("mismatch r_last expected %h got %h", exp_r_last[0], r_last));
            void'(exp_r_data.pop_front());
            void'(exp_r_id.pop_front());
            void'(exp_r_last.pop_front());
            r_beats <= r_beats + 1;
        end
    end

    // ====================================================================
    // Host and AFU models
    // ====================================================================

    // The host answers any outstanding line at random, so TLPs interleave
    always @(posedge afu_clk)
    begin
        int pick;
        cpl_valid <= 1'b0;
        tlp_credit <= 1'b0;
        if (tlp_req_valid)
        begin
            for (int k = 0; k <= int'(tlp_req_len); k++)
            begin
                pool_tag.push_back(host_rd_pkg::SLOT_WIDTH'(int'(tlp_req_tag) + k));
                pool_addr.push_back(tlp_req_addr + host_rd_pkg::ADDR_WIDTH'(k * 8));
            end
            tlp_owed++;
        end
        if (pool_tag.size() > 0 && $urandom_range(0, 99) < cpl_pct)
        begin
            pick = $urandom_range(0, pool_tag.size() - 1);
            cpl_valid <= 1'b1;
            cpl_tag <= pool_tag[pick];
            cpl_data <= line_data(pool_addr[pick]);
            pool_tag.delete(pick);
            pool_addr.delete(pick);
        end
        // Request credits come back after a random delay
        if (tlp_owed > 0 && $urandom_range(0, 3) == 0)
        begin
            tlp_credit <= 1'b1;
            tlp_owed--;
        end
    end

    // The AFU hands back one response credit per line unless it is stalling
    always @(posedge afu_clk)
    begin
        r_credit <= 1'b0;
        if (r_owed > 0 && !hold_credits && $urandom_range(0, 2) != 0)
        begin
            r_credit <= 1'b1;
            r_owed--;
        end
        if (r_valid)
        begin
            r_owed++;
        end
    end

    // Waits for a request credit, then drives one burst for a single cycle
    task automatic send_burst(input logic [host_rd_pkg::ADDR_WIDTH-1:0] addr, input int lines,
                              input logic [host_rd_pkg::ID_WIDTH-1:0] id);
        int waited;
        waited = 0;
        @(posedge afu_clk);
        while (ar_spent >= ar_returned + host_rd_pkg::AR_BUF_DEPTH)
        begin
            ar_valid <= 1'b0;
            waited++;
            assert (waited <= 500)
            else fail_with("timeout waiting for a request credit");
            @(posedge afu_clk);
        end
        ar_valid <= 1'b1;
        ar_addr <= addr;
        ar_len <= host_rd_pkg::LEN_WIDTH'(lines - 1);
        ar_id <= id;
        ar_spent++;
        expect_burst(addr, lines, id);
    endtask

    task automatic wait_idle(input int limit);
        int waited;
        waited = 0;
        @(posedge afu_clk);
        ar_valid <= 1'b0;
        while (exp_r_data.size() > 0 || exp_tlp_addr.size() > 0 || r_owed > 0)
        begin
            waited++;
            assert (waited <= limit)
            else fail_with("timeout waiting for all responses to drain");
            @(posedge afu_clk);
        end
        repeat (2) @(posedge afu_clk);
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        assert (actual == expected)
        else fail_with($sformatf("mismatch %s expected %h got %h", what, expected, actual));
    endtask

    // ====================================================================
    // Test sequence
    // ====================================================================

    initial
    begin
        int base;
        int avail;
        int waited;
        logic [host_rd_pkg::ADDR_WIDTH-1:0] addr;
        void'($urandom(79));
        arst_n <= 1'b0;
        repeat (3) @(posedge afu_clk);
        arst_n <= 1'b1;

        // One aligned 4-line burst is a single TLP
        base = tlp_seen;
        send_burst(32'h0000_2000, 4, 4'h3);
        wait_idle(300);
        check_count("tlp_req_valid count", 1, tlp_seen - base);

        // Two lines short of a page boundary gives chunks of 2, 4, 4, 4 and 2
        base = tlp_seen;
        send_burst(32'h0000_0FF0, 16, 4'hA);
        wait_idle(500);
        check_count("tlp_req_valid count", 5, tlp_seen - base);

        // A slow host lets beats of several TLPs pile up and mix
        cpl_pct = 20;
        send_burst(32'h0001_0000, 3, 4'h1);
        send_burst(32'h0001_1FE8, 8, 4'h2);
        send_burst(32'h0001_4000, 5, 4'h5);
        send_burst(32'h0001_5FF8, 7, 4'h7);
        wait_idle(1000);
        cpl_pct = 60;

        // With credits withheld only the free credits are used, then delivery resumes
        hold_credits = 1'b1;
        base = r_beats;
        avail = r_returned + host_rd_pkg::R_CREDITS_INIT - r_beats;
        send_burst(32'h0002_0000, 6, 4'h4);
        send_burst(32'h0002_0100, 6, 4'h6);
        waited = 0;
        @(posedge afu_clk);
        ar_valid <= 1'b0;
        while (r_beats - base < avail)
        begin
            waited++;
            assert (waited <= 500)
            else fail_with("timeout waiting for responses within the free credits");
            @(posedge afu_clk);
        end
        repeat (20) @(posedge afu_clk);
        check_count("r_valid count", avail, r_beats - base);
        hold_credits = 1'b0;
        wait_idle(1000);

        // Random bursts, half of them placed just below a page boundary
        for (int n = 0; n < 200; n++)
        begin
            if ($urandom_range(0, 1) == 1)
            begin
                addr = (32'($urandom_range(1, 255)) << 12) - (32'($urandom_range(1, 16)) << 3);
            end
            else
            begin
                addr = $urandom & 32'h000F_FFF8;
            end
            send_burst(addr, $urandom_range(1, 16), host_rd_pkg::ID_WIDTH'($urandom_range(0, 15)));
        end
        wait_idle(4000);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/host_rd_pkg.sv
rtl/host_rd_burst_splitter.sv
rtl/host_rd_rob.sv
rtl/host_rd_rsp_sender.sv
rtl/host_rd_top.sv
testbench/host_rd_checker.sv
testbench/host_rd_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the host read path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module host_rd_tb \
    -f flist.f -Mdir obj_dir || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vhost_rd_tb 2>&1)"
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
